// ==== fetch_pkg.sv ====
/*
   Fetch front end shared definitions
   ISA field layouts, opcode classes, FSM encodings
   and the bus and stage records passed between blocks
*/
`default_nettype none

package fetch_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // ISA constants
   ////////////////////////////////////////////////////////////////////////////

   // Opcodes with fixed meaning
   localparam logic [4:0] OP_HALT = 5'b00000;
   localparam logic [4:0] OP_NOP  = 5'b00001;
   localparam logic [4:0] OP_ALU_R = 5'b11011;

   // Bubble word, NOP opcode with zero fields
   localparam logic [15:0] NOP_WORD = {OP_NOP, 11'b0};

   // Opcode prefixes (top three bits)
   localparam logic [2:0] JUMP_CLASS_A = 3'b001;
   localparam logic [2:0] JUMP_CLASS_B = 3'b011;
   localparam logic [2:0] STORE_CLASS  = 3'b111;
   localparam logic [2:0] I_DST_CLASS_A = 3'b010;
   localparam logic [2:0] I_DST_CLASS_B = 3'b101;

   // {op[4:2], op[0]} of jumps that take no register
   localparam logic [3:0] JUMP_IMM_PAT = 4'b0010;

   // Byte addressed PC over 16-bit words
   localparam logic [15:0] PC_STEP = 16'd2;
   localparam int ROM_DEPTH = 64;
   localparam int ROM_AW = $clog2(ROM_DEPTH);

   // Fetch FSM encodings
   localparam logic [1:0] ST_REQ   = 2'd0;
   localparam logic [1:0] ST_WAIT  = 2'd1;
   localparam logic [1:0] ST_REDIR = 2'd2;
   localparam logic [1:0] ST_HALT  = 2'd3;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction word views
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_fmt_t;

   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } i_fmt_t;

   // Same 16 bits, two decodes
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } inst_u;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and stage records
   ////////////////////////////////////////////////////////////////////////////

   // Wishbone classic, read only
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic [15:0] adr;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [15:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
      inst_u       inst;
      logic        is_jump;
      logic        is_halt;
   } fetch_t;

   typedef struct packed {
      logic        valid;
      logic        bubble;
      logic [15:0] pc_next;
      logic [15:0] inst;
   } issue_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
   } redirect_t;

   typedef struct packed {
      logic       valid;
      logic [2:0] dst;
   } writeback_t;

endpackage

`default_nettype wire

// ==== inst_rom.sv ====
/*
   Instruction ROM
   Wishbone classic read slave, one registered ack per strobe
*/
`timescale 1ns/10ps
`default_nettype none

module inst_rom (
   input  logic                clk,
   input  logic                rst_n,
   input  fetch_pkg::wb_req_t  wb_req,
   output fetch_pkg::wb_rsp_t  wb_rsp
);

   // Word storage, contents from the program image
   logic [15:0] mem [0:fetch_pkg::ROM_DEPTH-1];

   logic        ack_q;
   logic [15:0] dat_q;
   logic [fetch_pkg::ROM_AW-1:0] word_idx;

   initial begin
      $readmemh("program.hex", mem);
   end

   // Byte address to word index, bit 0 ignored
   assign word_idx = wb_req.adr[fetch_pkg::ROM_AW:1];

   // Ack one cycle after strobe
   // Suppressed right after an ack so a held strobe is not answered twice
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_req.cyc & wb_req.stb & ~ack_q;
      end
   end

   // Read data registered alongside ack
   always_ff @(posedge clk) begin
      dat_q <= mem[word_idx];
   end

   always_comb begin
      wb_rsp.ack = ack_q;
      wb_rsp.dat = dat_q;
   end

endmodule

`default_nettype wire

// ==== pc_fetch.sv ====
/*
   PC and fetch control
   Drives the Wishbone master, captures words,
   flags jumps and halt, picks the next PC
*/
`timescale 1ns/10ps
`default_nettype none

module pc_fetch (
   input  logic                   clk,
   input  logic                   rst_n,
   output fetch_pkg::wb_req_t     wb_req,
   input  fetch_pkg::wb_rsp_t     wb_rsp,
   input  logic                   raw,
   input  fetch_pkg::redirect_t   redirect,
   output fetch_pkg::fetch_t      fetched
);

   logic [1:0]  state;
   logic [1:0]  state_nxt;
   logic [15:0] pc;
   logic [15:0] req_pc;
   logic        req_go;
   logic        started;

   // Captured word
   logic        f_valid;
   logic [15:0] f_pc;
   logic [15:0] f_inst;
   logic        f_jump;
   logic        f_halt;
   fetch_pkg::inst_u rsp_word;

   ////////////////////////////////////////////////////////////////////////////
   // Next request
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      req_go    = 1'b1;
      req_pc    = pc;
      state_nxt = state;
      case (state)
         fetch_pkg::ST_REQ: begin
            // Decide on the word that just came back
            // Hazard keeps pc for a refetch
            if (f_valid && !raw) begin
               if (f_jump || f_halt) begin
                  req_go = 1'b0;
               end else begin
                  req_pc = pc + fetch_pkg::PC_STEP;
               end
            end
            if (req_go) begin
               state_nxt = fetch_pkg::ST_WAIT;
            end else if (f_halt) begin
               state_nxt = fetch_pkg::ST_HALT;
            end else begin
               state_nxt = fetch_pkg::ST_REDIR;
            end
         end
         fetch_pkg::ST_WAIT: begin
            // Strobe held until ack is seen
            if (wb_rsp.ack) begin
               state_nxt = fetch_pkg::ST_REQ;
            end
         end
         fetch_pkg::ST_REDIR: begin
            req_go = 1'b0;
            // Reset exit behaves like a redirect to address 0
            if (!started || redirect.valid) begin
               state_nxt = fetch_pkg::ST_REQ;
            end
         end
         default: begin
            req_go = 1'b0;
         end
      endcase
   end

   always_comb begin
      wb_req.cyc = req_go;
      wb_req.stb = req_go;
      wb_req.adr = req_pc;
   end

   ////////////////////////////////////////////////////////////////////////////
   // State, PC and capture
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= fetch_pkg::ST_REDIR;
         started <= 1'b0;
         pc      <= '0;
         f_valid <= 1'b0;
      end else begin
         state   <= state_nxt;
         started <= 1'b1;
         if (state == fetch_pkg::ST_REDIR && started && redirect.valid) begin
            pc <= redirect.pc;
         end else if (state == fetch_pkg::ST_REQ) begin
            pc <= req_pc;
         end
         // One cycle pulse after ack
         f_valid <= (state == fetch_pkg::ST_WAIT) && wb_rsp.ack;
      end
   end

   assign rsp_word = wb_rsp.dat;

   always_ff @(posedge clk) begin
      if (state == fetch_pkg::ST_WAIT && wb_rsp.ack) begin
         f_pc   <= pc;
         f_inst <= wb_rsp.dat;
         f_jump <= (rsp_word.r.opcode[4:2] == fetch_pkg::JUMP_CLASS_A) ||
                   (rsp_word.r.opcode[4:2] == fetch_pkg::JUMP_CLASS_B);
         f_halt <= rsp_word.r.opcode == fetch_pkg::OP_HALT;
      end
   end

   always_comb begin
      fetched.valid   = f_valid;
      fetched.pc      = f_pc;
      fetched.inst    = f_inst;
      fetched.is_jump = f_jump;
      fetched.is_halt = f_halt;
   end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
/*
   RAW hazard detection
   Source and destination decode, 8-entry register scoreboard
*/
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
   input  logic                    clk,
   input  logic                    rst_n,
   input  fetch_pkg::fetch_t       fetched,
   input  fetch_pkg::writeback_t   wb,
   output logic                    raw
);

   fetch_pkg::inst_u word;
   logic [4:0] op;
   logic       rs_v;
   logic       rt_v;
   logic       rd_v;
   logic [2:0] rd;
   logic [7:0] pending;
   logic [7:0] set_mask;
   logic [7:0] clr_mask;

   assign word = fetched.inst;
   assign op   = word.r.opcode;

   ////////////////////////////////////////////////////////////////////////////
   // Operand decode
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      // rs read by everything but 000xx and immediate jumps
      rs_v = (op[4:2] != 3'b000) && ({op[4:2], op[0]} != fetch_pkg::JUMP_IMM_PAT);
      // rt only for register ALU ops and stores
      rt_v = (op == fetch_pkg::OP_ALU_R) || (op[4:2] == fetch_pkg::STORE_CLASS);

      // Destination field depends on format
      rd_v = 1'b0;
      rd   = word.i.rd;
      if (op == fetch_pkg::OP_ALU_R) begin
         rd_v = 1'b1;
         rd   = word.r.rd;
      end else if (op[4:2] == fetch_pkg::I_DST_CLASS_A ||
                   op[4:2] == fetch_pkg::I_DST_CLASS_B) begin
         rd_v = 1'b1;
      end
   end

   // Any live source still waiting on writeback
   assign raw = fetched.valid &&
                ((rs_v && pending[word.r.rs]) || (rt_v && pending[word.r.rt]));

   ////////////////////////////////////////////////////////////////////////////
   // Scoreboard
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      set_mask = '0;
      clr_mask = '0;
      // Set as the word moves into the issue register
      if (fetched.valid && !raw && rd_v) begin
         set_mask[rd] = 1'b1;
      end
      if (wb.valid) begin
         clr_mask[wb.dst] = 1'b1;
      end
   end

   // Set beats clear on the same register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= '0;
      end else begin
         pending <= (pending & ~clr_mask) | set_mask;
      end
   end

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
/*
   Issue register
   Bubble insertion on hazards, sticky dump on halt
*/
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  fetch_pkg::fetch_t   fetched,
   input  logic                raw,
   output fetch_pkg::issue_t   issue,
   output logic                dump
);

   logic        iss_valid;
   logic        iss_bubble;
   logic [15:0] iss_pc_next;
   logic [15:0] iss_inst;
   logic        halt_issue;

   // Halt counts only when it goes out for real
   assign halt_issue = fetched.valid && !raw && fetched.is_halt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         iss_valid <= 1'b0;
         dump      <= 1'b0;
      end else begin
         iss_valid <= fetched.valid;
         // Held until reset
         if (halt_issue) begin
            dump <= 1'b1;
         end
      end
   end

   // Payload, NOP in place of a hazarded word
   always_ff @(posedge clk) begin
      iss_bubble  <= raw;
      iss_pc_next <= fetched.pc + fetch_pkg::PC_STEP;
      iss_inst    <= raw ? fetch_pkg::NOP_WORD : fetched.inst;
   end

   always_comb begin
      issue.valid   = iss_valid;
      issue.bubble  = iss_bubble;
      issue.pc_next = iss_pc_next;
      issue.inst    = iss_inst;
   end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
/*
   Fetch and issue front end
   ROM, fetch control, hazard unit and issue register
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
   input  logic                    clk,
   input  logic                    rst_n,
   input  fetch_pkg::redirect_t    redirect,
   input  fetch_pkg::writeback_t   wb,
   output fetch_pkg::issue_t       issue,
   output logic                    dump
);

   fetch_pkg::wb_req_t wb_req;
   fetch_pkg::wb_rsp_t wb_rsp;
   fetch_pkg::fetch_t  fetched;
   logic               raw;

   // Instruction memory
   inst_rom inst_rom_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   // PC and bus master
   pc_fetch pc_fetch_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .raw      (raw),
      .redirect (redirect),
      .fetched  (fetched)
   );

   // Scoreboard, cleared by back end writebacks
   hazard_unit hazard_unit_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .fetched (fetched),
      .wb      (wb),
      .raw     (raw)
   );

   issue_stage issue_stage_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .fetched (fetched),
      .raw     (raw),
      .issue   (issue),
      .dump    (dump)
   );

endmodule

`default_nettype wire

// ==== fetch_unit_tb.sv ====
/*
   Fetch front end testbench
   Plays the back end with redirects and writebacks, tracks its own
   PC and scoreboard, and checks every issue against that model
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_unit_tb;

   localparam int CLK_PERIOD = 40;
   localparam int PROG_LEN   = 14;
   localparam int NUM_JUMPS  = 2;
   localparam int NUM_DSTS   = 5;
   localparam int HALT_IDLE  = 20;
   // Every word 40 cycles plus the worst case of all random delays
   localparam int WATCHDOG_CYCLES = PROG_LEN * 40 + NUM_JUMPS * 6 + NUM_DSTS * 9 + 4 + HALT_IDLE;
   localparam int SLOTS = WATCHDOG_CYCLES + 64;

   logic                  clk = 1'b0;
   logic                  rst_n = 1'b0;
   fetch_pkg::redirect_t  redirect = '0;
   fetch_pkg::writeback_t wb = '0;
   fetch_pkg::issue_t     issue;
   logic                  dump;

   // Reference model state
   logic [15:0]           prog [0:63];
   logic [15:0]           model_pc = '0;
   logic [7:0]            pend = '0;
   fetch_pkg::writeback_t wb_prev = '0;
   fetch_pkg::writeback_t wb_slot [0:SLOTS-1] = '{default: '0};
   fetch_pkg::redirect_t  redir_next = '0;
   int                    redir_at = -1;
   int                    cycle = 0;
   logic [15:0]           w;
   logic                  exp_bubble;
   logic [3:0]            set_dst;
   int                    slot;

   // Progress and bookkeeping
   logic seen_first = 1'b0;
   logic prev_valid = 1'b0;
   logic waiting_redir = 1'b0;
   logic halted = 1'b0;
   logic finished = 1'b0;
   int   since_rst = 0;
   int   checks = 0;
   int   bubbles = 0;
   int   jumps_issued = 0;
   int   idle_cnt = 0;
   int   total = 0;
   int   errs [1:5] = '{default: 0};

   fetch_unit fetch_unit_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .redirect (redirect),
      .wb       (wb),
      .issue    (issue),
      .dump     (dump)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // ISA rules
   ////////////////////////////////////////////////////////////////////////////

   // rs read unless 000xx or an immediate jump (001x0)
   function automatic logic rs_used(input logic [15:0] word);
      return (word[15:13] != 3'b000) && !(word[15:13] == 3'b001 && !word[11]);
   endfunction

   // rt read by register ALU and stores
   function automatic logic rt_used(input logic [15:0] word);
      return (word[15:11] == 5'b11011) || (word[15:13] == 3'b111);
   endfunction

   // {valid, register} of the destination
   function automatic logic [3:0] dest_of(input logic [15:0] word);
      if (word[15:11] == 5'b11011) begin
         return {1'b1, word[4:2]};
      end else if (word[15:13] == 3'b010 || word[15:13] == 3'b101) begin
         return {1'b1, word[7:5]};
      end
      return 4'b0;
   endfunction

   // Fixed redirect targets matching the program image
   function automatic logic [15:0] jump_target(input logic [15:0] pc);
      case (pc)
         16'h000A: return 16'h0010;
         16'h0012: return 16'h0018;
         default:  return pc + 16'd2;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Checks and reporting
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_val(input int beh, input string name,
                            input logic [15:0] exp, input logic [15:0] act);
      checks = checks + 1;
      assert (act === exp) else begin
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
         errs[beh] = errs[beh] + 1;
      end
   endtask

   task automatic check_true(input int beh, input logic cond, input string what);
      checks = checks + 1;
      assert (cond) else begin
         $display("Behavior %0d failed: %s", beh, what);
         errs[beh] = errs[beh] + 1;
      end
   endtask

   task automatic report_result(input int beh, input string name);
      $display("Behavior %0d, %s: %s", beh, name, (errs[beh] == 0) ? "pass" : "fail");
   endtask

   // One issue against the model word at model_pc
   task automatic check_issue();
      w = prog[model_pc[6:1]];
      exp_bubble = (rs_used(w) && pend[w[10:8]]) || (rt_used(w) && pend[w[7:5]]);
      check_val(2, "issue.pc_next", model_pc + 16'd2, issue.pc_next);
      check_val(3, "issue.bubble", 16'(exp_bubble), 16'(issue.bubble));
      // Coverage counts from what the DUT put out
      if (issue.bubble) begin
         bubbles = bubbles + 1;
      end else if (issue.inst[15:13] == 3'b001 || issue.inst[15:13] == 3'b011) begin
         jumps_issued = jumps_issued + 1;
      end
      if (exp_bubble) begin
         check_val(3, "issue.inst", 16'h0800, issue.inst);
      end else begin
         check_val(2, "issue.inst", w, issue.inst);
         set_dst = dest_of(w);
         // Writeback 2 to 9 cycles out
         // Collision moves it to the next free slot
         if (set_dst[3]) begin
            slot = cycle + 2 + int'($urandom % 8);
            while (slot < SLOTS - 1 && wb_slot[slot].valid) begin
               slot = slot + 1;
            end
            wb_slot[slot] = {1'b1, set_dst[2:0]};
         end
         if (w[15:13] == 3'b001 || w[15:13] == 3'b011) begin
            waiting_redir = 1'b1;
            redir_next = {1'b1, jump_target(model_pc)};
            redir_at = cycle + 1 + int'($urandom % 6);
            model_pc = jump_target(model_pc);
         end else if (w[15:11] == 5'b00000) begin
            halted = 1'b1;
         end else begin
            model_pc = model_pc + 16'd2;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Back end responder driving on the rising edge
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle < SLOTS) begin
         wb <= wb_slot[cycle];
      end else begin
         wb <= '0;
      end
      // One cycle redirect pulse
      if (cycle == redir_at) begin
         redirect <= redir_next;
      end else begin
         redirect <= '0;
      end
   end

   // Outputs sampled mid cycle
   always @(negedge clk) begin
      if (!rst_n) begin
         since_rst = 0;
         pend = '0;
         wb_prev = '0;
      end else begin
         set_dst = 4'b0;
         if (redirect.valid) begin
            waiting_redir = 1'b0;
         end
         if (issue.valid) begin
            if (!seen_first) begin
               seen_first = 1'b1;
               check_val(1, "first issue cycle", 16'd4, 16'(since_rst));
               report_result(1, "reset and first issue");
            end
            check_true(2, !prev_valid, "issue valid high in two cycles in a row");
            if (halted) begin
               check_true(5, 1'b0, "an issue appeared after halt");
            end else if (waiting_redir) begin
               check_true(4, 1'b0, "an issue appeared before the redirect");
            end else begin
               check_issue();
            end
         end else if (!seen_first) begin
            check_true(1, since_rst != 4, "no issue 4 cycles after reset");
         end
         check_val(seen_first ? 5 : 1, "dump", 16'(halted), 16'(dump));

         // Scoreboard as the DUT holds it after this edge
         // Set wins over clear
         if (wb_prev.valid) begin
            pend[wb_prev.dst] = 1'b0;
         end
         if (set_dst[3]) begin
            pend[set_dst[2:0]] = 1'b1;
         end
         wb_prev = wb;
         prev_valid = issue.valid;

         // Quiet window after halt before the coverage checks
         if (halted && !finished) begin
            idle_cnt = idle_cnt + 1;
            if (idle_cnt > HALT_IDLE) begin
               check_true(3, bubbles > 0, "no hazard bubble was issued");
               check_true(4, jumps_issued == NUM_JUMPS, "jump issue count differs from program");
               finished = 1'b1;
            end
         end
         since_rst = since_rst + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Run control
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'hd28f));
      $readmemh("program.hex", prog);
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      wait (finished);
      report_result(2, "issued words and pc_next");
      report_result(3, "hazard bubbles");
      report_result(4, "jump and redirect");
      report_result(5, "halt and dump");
      total = errs[1] + errs[2] + errs[3] + errs[4] + errs[5];
      $display("Checks: %0d, errors: %0d", checks, total);
      if (total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: program did not halt within %0d cycles", WATCHDOG_CYCLES);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== program.hex ====
// One 16-bit instruction word per line in hex, starting at pc 0x00
// Columns: the word, then its pc and what it does
DA64 // pc 00  alu r1 = r2, r3
49C1 // pc 02  imm r6 from r1, waits on r1
44A3 // pc 04  imm r5 from r4
E6A0 // pc 06  store r5 to r6
0800 // pc 08  nop
2000 // pc 0A  jump immediate, target pc 10
4A5A // pc 0C  skipped
4B5B // pc 0E  skipped
5AE2 // pc 10  imm r7 from r2, jump target
6700 // pc 12  jump register r7, waits on r7, target pc 18
4C5C // pc 14  skipped
4D5D // pc 16  skipped
A344 // pc 18  imm r2 from r3, jump target
0000 // pc 1A  halt

// ==== sources.f ====
fetch_pkg.sv
inst_rom.sv
pc_fetch.sv
hazard_unit.sv
issue_stage.sv
fetch_unit.sv
fetch_unit_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the fetch front end

TOP := fetch_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module fetch_unit

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
